// ==== all.f ====
+incdir+tb
rtl/ocyrus_pkg.sv
rtl/word_strobe_gen.sv
rtl/lock_monitor.sv
rtl/oserdes_lane.sv
rtl/ocyrus_double8.sv
tb/tb_ocyrus_double8.sv

// ==== tb/tb_ocyrus_tasks.svh ====
`ifndef TB_OCYRUS_TASKS_SVH
`define TB_OCYRUS_TASKS_SVH

// compare one sampled bit against its expected level
task automatic check_bit(input string test_name, input string what,
		input logic expected, input logic actual);
	assert (actual === expected) else begin
		error_count++;
		$display("Fail %s, %s: expected %b, actual %b", test_name, what, expected, actual);
		$display("sim failed");
		$fatal(1);
	end
endtask

// compare two counts such as the spacing of word clock rises
task automatic check_int(input string test_name, input string what,
		input int expected, input int actual);
	assert (actual == expected) else begin
		error_count++;
		$display("Fail %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
		$display("sim failed");
		$fatal(1);
	end
endtask

// all four serial pins low
task automatic expect_quiet(input string test_name);
	check_bit(test_name, "t1_out low", 1'b0, t1_out);
	check_bit(test_name, "d1_out low", 1'b0, d1_out);
	check_bit(test_name, "t2_out low", 1'b0, t2_out);
	check_bit(test_name, "d2_out low", 1'b0, d2_out);
endtask

// pins, lock and word clock all low as right after reset
task automatic expect_idle(input string test_name);
	expect_quiet(test_name);
	check_bit(test_name, "locked low", 1'b0, locked);
	check_bit(test_name, "word_clock_out low", 1'b0, word_clock_out);
endtask

// drive new words on a falling edge for the next word clock rise
task automatic drive_words(input ocyrus_pkg::word_t w1, input ocyrus_pkg::word_t w2);
	word1_in = w1;
	word2_in = w2;
endtask

// reset for two rising edges with the outputs checked after each one
// starts at time 0 or on a falling edge and returns on the falling edge of release
task automatic apply_reset(input string test_name);
	reset = 1'b1;
	repeat (2) begin
		@(negedge clock_in);
		expect_idle(test_name); // cleared by the edge just taken with reset high
	end
	reset = 1'b0;
	sent1_q.delete(); // words in flight are lost
	sent2_q.delete();
endtask

// returns on the falling edge right after the next word clock rise
task automatic wait_word_rise();
	logic prev_level; // word clock at the previous falling edge

	prev_level = word_clock_out;
	@(negedge clock_in);
	while (!(word_clock_out && !prev_level)) begin
		prev_level = word_clock_out;
		@(negedge clock_in);
	end
endtask

// wait for a rise and keep the words the lanes captured on it
task automatic record_rise();
	wait_word_rise();
	sent1_q.push_back(word1_in); // inputs were held through the rise
	sent2_q.push_back(word2_in);
	last_rise_cycle = cycle_count;
endtask

// check the oldest recorded word on the pins msb first with one bit per cycle
// starts on the falling edge after the rise and checks the top bit_total bits
task automatic check_sent_bits(input string test_name, input int bit_total);
	ocyrus_pkg::word_t exp1; // word1 captured at the rise
	ocyrus_pkg::word_t exp2; // word2 captured at the rise
	int n;
	int idx;

	assert (sent1_q.size() != 0 && sent2_q.size() != 0) else begin
		error_count++;
		$display("%s: pins checked but no word was recorded at a word clock rise", test_name);
		$display("sim failed");
		$fatal(1);
	end
	exp1 = sent1_q.pop_front();
	exp2 = sent2_q.pop_front();
	for (n = 0; n < bit_total; n++) begin
		if (n > 0) begin
			@(negedge clock_in); // next bit one fast cycle later
		end
		idx = ocyrus_pkg::WIDTH - 1 - n; // msb leaves first
		check_bit(test_name, $sformatf("t1_out bit %0d of %h", idx, exp1), exp1[idx], t1_out);
		check_bit(test_name, $sformatf("d1_out bit %0d of %h", idx, exp1), exp1[idx], d1_out);
		check_bit(test_name, $sformatf("t2_out bit %0d of %h", idx, exp2), exp2[idx], t2_out);
		check_bit(test_name, $sformatf("d2_out bit %0d of %h", idx, exp2), exp2[idx], d2_out);
		check_bit(test_name, $sformatf("word_clock_out in bit cycle %0d", n),
			n < ocyrus_pkg::WIDTH / 2, word_clock_out); // high for the first half
		check_bit(test_name, "locked high while sending", 1'b1, locked);
	end
endtask

// count word clock rises after reset as locked must follow the 4th one
// pins stay low all along since nothing loads before that rise
// returns on the falling edge after the LOCK_WORDS-th rise
task automatic lock_sequence(input string test_name);
	logic prev_level; // word clock at the previous falling edge
	int rises; // word clock rises since reset

	prev_level = word_clock_out;
	rises = 0;
	while (rises < ocyrus_pkg::LOCK_WORDS) begin
		@(negedge clock_in);
		if (word_clock_out && !prev_level) begin
			rises++;
		end
		prev_level = word_clock_out;
		check_bit(test_name, $sformatf("locked after %0d rises", rises),
			rises >= ocyrus_pkg::LOCK_WORDS, locked);
		expect_quiet(test_name);
	end
endtask

// reset state and the first cycle after reset
task automatic reset_state_test();
	apply_reset("reset_state");
	@(negedge clock_in);
	expect_idle("reset_state"); // one cycle after release, still quiet
endtask

// lock after four word periods with silent pins
task automatic lock_test();
	lock_sequence("lock");
endtask

// fixed words sent msb first on the 5th rise
task automatic msb_first_test();
	drive_words(8'hA5, 8'h3C); // held through the next rise
	record_rise();
	drive_words('0, '0);
	check_sent_bits("msb_first", ocyrus_pkg::WIDTH);
endtask

// random words back to back
// the loop starts with the zero word left by the previous test
// then 16 random pairs follow with rises exactly one word period apart
task automatic back_to_back_test();
	int k;
	int prev_rise; // cycle of the rise before this one
	logic [31:0] rnd1;
	logic [31:0] rnd2;

	for (k = 0; k <= 16; k++) begin
		prev_rise = last_rise_cycle;
		record_rise();
		check_int("back_to_back", "cycles between word clock rises",
			ocyrus_pkg::WIDTH, last_rise_cycle - prev_rise);
		if (k < 16) begin
			rnd1 = $urandom;
			rnd2 = $urandom;
			drive_words(rnd1[7:0], rnd2[7:0]); // captured at the next rise
		end else begin
			drive_words('0, '0);
		end
		check_sent_bits("back_to_back", ocyrus_pkg::WIDTH);
	end
endtask

// reset inside a word and then the lock sequence again
task automatic reset_mid_stream_test();
	logic [31:0] rnd1;
	logic [31:0] rnd2;

	record_rise(); // zero word from the stream test
	drive_words(8'hC3, 8'h5A);
	check_sent_bits("reset_mid_stream", ocyrus_pkg::WIDTH);
	record_rise(); // c3 and 5a go out now
	drive_words('0, '0);
	check_sent_bits("reset_mid_stream", 3); // word still in flight after three bits
	apply_reset("reset_mid_stream");
	@(negedge clock_in);
	expect_idle("reset_mid_stream");
	lock_sequence("reset_mid_stream");
	rnd1 = $urandom;
	rnd2 = $urandom;
	drive_words(rnd1[7:0], rnd2[7:0]); // first word after the relock
	record_rise();
	drive_words('0, '0);
	check_sent_bits("reset_mid_stream", ocyrus_pkg::WIDTH);
endtask

`endif

// ==== tb/tb_ocyrus_double8.sv ====
`timescale 1ns/100ps

// testbench top for the double-word transmit serializer
// clock, reset, dut, cycle limit and the order of the directed tests
module tb_ocyrus_double8;

	localparam int CLOCK_HALF = 10; // 20 ns bit clock
	localparam int WORD_CYCLES = ocyrus_pkg::WIDTH; // fast cycles per word period

	// reset and lock take about 6 word periods, msb word 1, stream 17,
	// mid-stream reset with relock and one word about 10
	// rounded up to 50 word periods for the whole run
	localparam int TEST_WORDS = 50;
	localparam int TIMEOUT_CYCLES = 5 * TEST_WORDS * WORD_CYCLES; // 2000 cycles for five times the run

	// dut inputs
	logic clock_in; // fast bit clock
	logic reset; // synchronous, active high
	ocyrus_pkg::word_t word1_in; // word for t1 and d1
	ocyrus_pkg::word_t word2_in; // word for t2 and d2

	// dut outputs
	logic word_clock_out; // divided word clock
	logic t1_out; // word1 serial pins
	logic d1_out;
	logic t2_out; // word2 serial pins
	logic d2_out;
	logic locked; // lock model output

	// bookkeeping
	int cycle_count; // rising edges since time 0
	int error_count; // failed checks
	int last_rise_cycle; // cycle count at the latest word clock rise

	// words present at each word clock rise, oldest first
	ocyrus_pkg::word_t sent1_q[$];
	ocyrus_pkg::word_t sent2_q[$];

	ocyrus_double8 ocyrus_double8_i (
		.clock_in(clock_in),
		.reset(reset),
		.word1_in(word1_in),
		.word2_in(word2_in),
		.word_clock_out(word_clock_out),
		.t1_out(t1_out),
		.d1_out(d1_out),
		.t2_out(t2_out),
		.d2_out(d2_out),
		.locked(locked)
	);

	// bit clock starts low and first rises at 10 ns
	initial begin
		clock_in = 1'b0;
		forever begin
			#CLOCK_HALF clock_in = ~clock_in;
		end
	end

	// cycle counter for the timeout and the word clock rise times
	initial begin
		cycle_count = 0;
	end

	always @(posedge clock_in) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$fatal(1);
		end
	end

	// directed test tasks and their helpers
	`include "tb_ocyrus_tasks.svh"

	// test sequence
	initial begin
		reset = 1'b1; // held from time 0, released by the first test
		word1_in = '0;
		word2_in = '0;
		error_count = 0;
		last_rise_cycle = 0;
		void'($urandom(90813)); // one seed for the whole run

		reset_state_test(); // outputs quiet in and just after reset
		lock_test(); // locked on the 4th word clock rise
		msb_first_test(); // a5 and 3c bit by bit
		back_to_back_test(); // random words with no gap
		reset_mid_stream_test(); // reset inside a word, relock, resend

		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== rtl/ocyrus_double8.sv ====
`timescale 1ns/100ps

// double-word transmit serializer
// two 8-bit words enter on the word clock, each goes out on a t pin and a d pin
module ocyrus_double8 (
	input logic clock_in, // fast bit clock, replaces the pll xn output
	input logic reset, // synchronous, active high
	input ocyrus_pkg::word_t word1_in, // word for t1 and d1
	input ocyrus_pkg::word_t word2_in, // word for t2 and d2
	output logic word_clock_out, // divided word clock, words sampled on its rise
	output logic t1_out, // word1 serial, msb first
	output logic d1_out, // word1 serial, msb first
	output logic t2_out, // word2 serial, msb first
	output logic d2_out, // word2 serial, msb first
	output logic locked // clocking ready, words are being sent
);

	logic load_strobe; // shared serdes strobe for all four lanes

	// strobe and word clock from one bit counter
	word_strobe_gen strobe_gen (
		.clock_in(clock_in),
		.reset(reset),
		.load_strobe(load_strobe),
		.word_clock_out(word_clock_out)
	);

	// lock model, gates the lane loads
	lock_monitor lock_mon (
		.clock_in(clock_in),
		.reset(reset),
		.load_strobe(load_strobe),
		.locked(locked)
	);

	// word1 goes out twice, t and d are separate serializers on the same word
	oserdes_lane lane_t1 (
		.clock_in(clock_in),
		.reset(reset),
		.load(load_strobe),
		.enable(locked),
		.word_in(word1_in),
		.serial_out(t1_out)
	);

	oserdes_lane lane_d1 (
		.clock_in(clock_in),
		.reset(reset),
		.load(load_strobe),
		.enable(locked),
		.word_in(word1_in),
		.serial_out(d1_out)
	);

	// same arrangement for word2
	oserdes_lane lane_t2 (
		.clock_in(clock_in),
		.reset(reset),
		.load(load_strobe),
		.enable(locked),
		.word_in(word2_in),
		.serial_out(t2_out)
	);

	oserdes_lane lane_d2 (
		.clock_in(clock_in),
		.reset(reset),
		.load(load_strobe),
		.enable(locked),
		.word_in(word2_in),
		.serial_out(d2_out)
	);

endmodule

// ==== rtl/oserdes_lane.sv ====
`timescale 1ns/100ps

// one output serializer, the behavioural stand-in for a master/slave oserdes pair
// parallel load on the strobe, then one bit per fast clock, msb first
module oserdes_lane (
	input logic clock_in, // fast bit clock
	input logic reset, // synchronous, active high
	input logic load, // serdes strobe, last bit of the word period
	input logic enable, // load enable, the lock flag
	input ocyrus_pkg::word_t word_in, // parallel word to send
	output logic serial_out // serial pin, msb first
);

	ocyrus_pkg::word_t shift_reg; // word being sent, msb at the top
	logic load_now; // strobe qualified by lock

	// no load before lock, so the register shifts out zeros
	assign load_now = load && enable;

	// parallel load or shift left
	// back-to-back loads land right after the previous lsb, no gap
	always_ff @(posedge clock_in) begin
		if (reset) begin
			shift_reg <= '0; // pin reads 0 after reset
		end else if (load_now) begin
			shift_reg <= word_in; // capture on the wrap edge
		end else begin
			shift_reg <= {shift_reg[ocyrus_pkg::WIDTH-2:0], 1'b0}; // next bit up, fill 0
		end
	end

	// the pin is the top bit of the register
	// cycle after the load edge shows bit WIDTH-1, seven cycles later bit 0
	assign serial_out = shift_reg[ocyrus_pkg::WIDTH-1];

endmodule

// ==== rtl/lock_monitor.sv ====
`timescale 1ns/100ps

// stands in for the pll lock anded with the bufpll strobe alignment
// locked comes up after a fixed count of word periods and stays up
module lock_monitor (
	input logic clock_in, // fast bit clock
	input logic reset, // synchronous, active high, drops locked
	input logic load_strobe, // one pulse per word period
	output logic locked // sticky until the next reset
);

	ocyrus_pkg::lock_count_t strobe_count; // strobes seen since reset
	logic count_full; // this strobe is the last one needed
	logic count_step; // advance the counter on this edge

	// the LOCK_WORDS-th strobe sets locked on its own edge
	assign count_full = (strobe_count == ocyrus_pkg::lock_count_t'(ocyrus_pkg::LOCK_WORDS - 1));

	// counter stops once locked, so it saturates at LOCK_WORDS
	assign count_step = load_strobe && !locked;

	// strobe counter
	always_ff @(posedge clock_in) begin
		if (reset) begin
			strobe_count <= '0;
		end else if (count_step) begin
			strobe_count <= strobe_count + 1'b1; // never wraps, held after lock
		end
	end

	// sticky lock flag
	always_ff @(posedge clock_in) begin
		if (reset) begin
			locked <= 1'b0; // pins stay quiet until lock
		end else if (count_step && count_full) begin
			locked <= 1'b1; // rises together with the 4th word clock rise
		end
	end

endmodule

// ==== rtl/word_strobe_gen.sv ====
`timescale 1ns/100ps

// fabric stand-in for the bufpll serdes strobe and the divided pll output
// one counter on the fast clock makes both the load strobe and the word clock
module word_strobe_gen (
	input logic clock_in, // fast bit clock, one bit per cycle
	input logic reset, // synchronous, active high
	output logic load_strobe, // one cycle pulse on the last bit of a word
	output logic word_clock_out // divided clock, high for first half of a word
);

	ocyrus_pkg::bit_count_t bit_count; // position within the current word period
	logic last_bit; // count sits at WIDTH-1, next edge wraps
	logic in_first_half; // still inside the high half after a wrap

	// decode of the counter
	assign last_bit = (bit_count == ocyrus_pkg::bit_count_t'(ocyrus_pkg::WIDTH - 1));
	assign in_first_half = (bit_count < ocyrus_pkg::bit_count_t'(ocyrus_pkg::WIDTH / 2 - 1));

	// bit counter, wraps every WIDTH cycles
	always_ff @(posedge clock_in) begin
		if (reset) begin
			bit_count <= '0; // first word period starts right after reset
		end else if (last_bit) begin
			bit_count <= '0; // wrap edge
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// the strobe is the plain decode, so it lands in the cycle before the wrap
	// and the lanes load on the wrap edge itself
	assign load_strobe = last_bit;

	// registered word clock
	// rises on the wrap edge, holds for WIDTH/2 cycles, then drops
	// the counter runs from 0 after reset without a wrap, so the clock
	// stays low until the first real word boundary
	always_ff @(posedge clock_in) begin
		if (reset) begin
			word_clock_out <= 1'b0;
		end else if (last_bit) begin
			word_clock_out <= 1'b1; // rising edge coincides with the wrap
		end else if (!in_first_half) begin
			word_clock_out <= 1'b0; // second half of the word period
		end
	end

endmodule

// ==== rtl/ocyrus_pkg.sv ====
package ocyrus_pkg;

	// word geometry
	localparam int WIDTH = 8; // bits per parallel word, sent msb first

	// lock model
	// the pll and bufpll lock of the hardware is replaced by a fixed
	// number of word periods counted after reset
	localparam int LOCK_WORDS = 4; // load strobes seen before locked rises

	// a parallel word as it enters on word1_in / word2_in
	typedef logic [WIDTH-1:0] word_t;

	// bit position inside one word period, 0 .. WIDTH-1
	typedef logic [$clog2(WIDTH)-1:0] bit_count_t;

	// strobe count of the lock monitor, saturates at LOCK_WORDS
	typedef logic [2:0] lock_count_t;

endpackage
